// File: source/keypad_pkg.sv
/*
 * Keypad display package
 * Timing constants in clock cycles, counter widths, vector types and the key map
 */
package keypad_pkg;

    typedef logic [3:0] key_code_t;     // Hex key value 0 to F
    typedef logic [3:0] line_vec_t;     // One bit per keypad column or row
    typedef logic [6:0] seg_t;          // Active low, g down to a

    // Scan timing, all in clk cycles
    localparam int SCAN_DWELL      = 4; // Must exceed SYNC_STAGES
    localparam int DEBOUNCE_CYCLES = 6;
    localparam int RELEASE_CYCLES  = 6;
    localparam int REFRESH_CYCLES  = 8;
    localparam int SYNC_STAGES     = 3;

    // Counter widths derived from the timing constants
    localparam int DWELL_W   = $clog2(SCAN_DWELL);
    localparam int STABLE_W  = $clog2((DEBOUNCE_CYCLES > RELEASE_CYCLES) ?
                                      DEBOUNCE_CYCLES : RELEASE_CYCLES) + 1;
    localparam int REFRESH_W = $clog2(REFRESH_CYCLES);

    /*
     * Key map indexed by {column, row}.
     * Each group of four is one column, rows 0 to 3.
     */
    localparam key_code_t KEY_MAP [16] = '{
        4'h1, 4'h4, 4'h7, 4'hA,         // Column 0
        4'h2, 4'h5, 4'h8, 4'h0,         // Column 1
        4'h3, 4'h6, 4'h9, 4'hB,         // Column 2
        4'hC, 4'hD, 4'hE, 4'hF          // Column 3
    };

endpackage

// File: source/seven_seg_decoder.sv
/*
 * Hex to seven-segment decoder, active low segments g down to a
 */
`timescale 1ns/100ps

module seven_seg_decoder
    import keypad_pkg::*;
(
    input  key_code_t hex_value,
    output seg_t      seg
);

    always_comb begin
        case (hex_value)
            4'h0: seg = 7'b100_0000;
            4'h1: seg = 7'b111_1001;
            4'h2: seg = 7'b010_0100;
            4'h3: seg = 7'b011_0000;
            4'h4: seg = 7'b001_1001;
            4'h5: seg = 7'b001_0010;
            4'h6: seg = 7'b000_0010;
            4'h7: seg = 7'b111_1000;
            4'h8: seg = 7'b000_0000;
            4'h9: seg = 7'b001_0000;
            4'hA: seg = 7'b000_1000;
            4'hB: seg = 7'b000_0011;    // Lower case b
            4'hC: seg = 7'b100_0110;
            4'hD: seg = 7'b010_0001;    // Lower case d
            4'hE: seg = 7'b000_0110;
            default: seg = 7'b000_1110; // F
        endcase
    end

endmodule

// File: source/keypad_scanner.sv
/*
 * Keypad scanner
 * Walks the columns, synchronizes the rows, debounces one single-row hit
 * and emits one key_valid strobe per press, then waits for release
 */
`timescale 1ns/100ps

module keypad_scanner
    import keypad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  line_vec_t keypad_rows,
    output line_vec_t keypad_cols,
    output key_code_t key_code,
    output logic      key_valid
);

    typedef enum logic [2:0] {
        scan_col0,
        scan_col1,
        scan_col2,
        scan_col3,
        verify,
        hold
    } scan_state_t;

    scan_state_t         state;
    scan_state_t         next_scan;
    line_vec_t           rows_sync [SYNC_STAGES];
    line_vec_t           rows_s;
    logic [DWELL_W-1:0]  dwell_cnt;
    logic [STABLE_W-1:0] stable_cnt;
    logic [1:0]          active_col;
    logic [1:0]          cap_col;
    line_vec_t           cap_row;
    logic [1:0]          row_idx;
    key_code_t           decoded_key;
    logic                scanning;
    logic                dwell_done;
    logic                row_hit;
    logic                row_match;
    logic                rows_idle;
    logic                debounce_done;
    logic                release_done;
    logic                capture;
    logic                fire;

    // Row synchronizer, rows_s is the last stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_sync <= '{default: '0};
        end else begin
            rows_sync[0] <= keypad_rows;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                rows_sync[i] <= rows_sync[i-1];
            end
        end
    end

    assign rows_s = rows_sync[SYNC_STAGES-1];

    // Column driven low and the column that follows it in the scan
    always_comb begin
        next_scan = scan_col0;
        case (state)
            scan_col0: begin
                active_col = 2'd0;
                next_scan  = scan_col1;
            end
            scan_col1: begin
                active_col = 2'd1;
                next_scan  = scan_col2;
            end
            scan_col2: begin
                active_col = 2'd2;
                next_scan  = scan_col3;
            end
            scan_col3: begin
                active_col = 2'd3;
                next_scan  = scan_col0;
            end
            default:   active_col = cap_col;   // Verify and hold keep the hit column low
        endcase
    end

    assign keypad_cols = ~(line_vec_t'(1) << active_col);

    assign scanning      = state inside {scan_col0, scan_col1, scan_col2, scan_col3};
    // Rows only reflect this column once the synchronizer has refilled
    assign dwell_done    = dwell_cnt == DWELL_W'(SCAN_DWELL - 1);
    assign row_hit       = $onehot(rows_s);
    assign row_match     = rows_s == cap_row;
    assign rows_idle     = rows_s == '0;
    assign debounce_done = stable_cnt == STABLE_W'(DEBOUNCE_CYCLES - 1);
    assign release_done  = stable_cnt == STABLE_W'(RELEASE_CYCLES - 1);
    assign capture       = scanning && dwell_done && row_hit;
    assign fire          = (state == verify) && row_match && debounce_done;

    // One-hot captured row to row number
    always_comb begin
        case (cap_row)
            4'b0010: row_idx = 2'd1;
            4'b0100: row_idx = 2'd2;
            4'b1000: row_idx = 2'd3;
            default: row_idx = 2'd0;
        endcase
    end

    assign decoded_key = KEY_MAP[{cap_col, row_idx}];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= scan_col0;
            dwell_cnt  <= '0;
            stable_cnt <= '0;
            key_valid  <= 1'b0;
        end else begin
            key_valid <= fire;
            case (state)
                scan_col0, scan_col1, scan_col2, scan_col3: begin
                    if (!dwell_done) begin
                        dwell_cnt <= dwell_cnt + 1'b1;
                    end else begin
                        dwell_cnt <= '0;
                        if (row_hit) begin
                            stable_cnt <= '0;
                            state      <= verify;
                        end else begin
                            state <= next_scan;
                        end
                    end
                end
                verify: begin
                    if (!row_match) begin
                        state <= scan_col0;       // Bounce or a second row, rescan
                    end else if (debounce_done) begin
                        stable_cnt <= '0;
                        state      <= hold;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                hold: begin
                    if (!rows_idle) begin
                        stable_cnt <= '0;
                    end else if (release_done) begin
                        stable_cnt <= '0;
                        state      <= scan_col0;
                    end else begin
                        stable_cnt <= stable_cnt + 1'b1;
                    end
                end
                default: state <= scan_col0;
            endcase
        end
    end

    // Hit position and decoded key
    always_ff @(posedge clk) begin
        if (capture) begin
            cap_col <= active_col;
            cap_row <= rows_s;
        end
        if (fire) begin
            key_code <= decoded_key;
        end
    end

    // One column low, and it stays put from capture until the scan resumes
    a_cols_one_cold: assert property (@(posedge clk) disable iff (!rst_n)
        ($onehot(~keypad_cols) || (keypad_cols == 4'b1111)) &&
        (scanning || $past(scanning) || $stable(keypad_cols)))
        else $error("keypad_cols not one-cold or moved during a press: %b", keypad_cols);

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |=> !key_valid)
        else $error("key_valid high two cycles in a row");

    a_valid_from_verify: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> ($past(state == verify) && (state == hold)))
        else $error("key_valid raised outside the verify to hold step");

endmodule

// File: source/key_history.sv
/*
 * Key history
 * Two-deep shift of accepted key codes, newest and previous
 */
`timescale 1ns/100ps

module key_history
    import keypad_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_valid,
    input  key_code_t key_code,
    output key_code_t newest_key,
    output key_code_t previous_key
);

    // Shift on each accepted press
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            newest_key   <= '0;
            previous_key <= '0;
        end else if (key_valid) begin
            previous_key <= newest_key;
            newest_key   <= key_code;
        end
    end

    // Display contents only move after a press was accepted
    a_change_on_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(newest_key) || $changed(previous_key)) |-> $past(key_valid))
        else $error("history changed without key_valid");

endmodule

// File: source/display_mux.sv
/*
 * Two-digit display multiplexer
 * Alternates the digits every REFRESH_CYCLES through one shared decoder
 */
`timescale 1ns/100ps

module display_mux
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  key_code_t  newest_key,
    input  key_code_t  previous_key,
    output seg_t       seg,
    output logic [1:0] digit_en
);

    logic [REFRESH_W-1:0] refresh_cnt;
    logic                 refresh_end;
    logic [1:0]           en_next;
    key_code_t            shown_key;
    seg_t                 seg_next;

    assign refresh_end = refresh_cnt == REFRESH_W'(REFRESH_CYCLES - 1);
    assign en_next     = refresh_end ? ~digit_en : digit_en;

    // Decode the digit that will be enabled next cycle, bit 1 is newest
    assign shown_key = en_next[1] ? previous_key : newest_key;

    seven_seg_decoder seven_seg_decoder_i (
        .hex_value (shown_key),
        .seg       (seg_next)
    );

    // Pattern and enable move together so no ghosting appears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            refresh_cnt <= '0;
            digit_en    <= 2'b01;
            seg         <= 7'b100_0000; // Glyph 0, history is cleared
        end else begin
            refresh_cnt <= refresh_end ? '0 : refresh_cnt + 1'b1;
            digit_en    <= en_next;
            seg         <= seg_next;
        end
    end

    a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~digit_en))
        else $error("digit_en not one-cold: %b", digit_en);

endmodule

// File: source/keypad_display_top.sv
/*
 * Keypad display top
 * Scanner feeds the key history, history feeds the two-digit display
 */
`timescale 1ns/100ps

module keypad_display_top
    import keypad_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  line_vec_t  keypad_rows,
    output line_vec_t  keypad_cols,
    output seg_t       seg,
    output logic [1:0] digit_en,
    output logic       key_valid
);

    key_code_t key_code;
    key_code_t newest_key;
    key_code_t previous_key;

    keypad_scanner keypad_scanner_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_rows (keypad_rows),
        .keypad_cols (keypad_cols),
        .key_code    (key_code),
        .key_valid   (key_valid)
    );

    // Last two accepted keys
    key_history key_history_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .newest_key   (newest_key),
        .previous_key (previous_key)
    );

    display_mux display_mux_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .newest_key   (newest_key),
        .previous_key (previous_key),
        .seg          (seg),
        .digit_en     (digit_en)
    );

endmodule

// File: test/keypad_model.sv
/*
 * Keypad switch matrix model
 * Up to two closed keys tie their row to their column while that column is low
 */
`timescale 1ns/100ps

module keypad_model
    import keypad_pkg::*;
(
    input  line_vec_t  keypad_cols,
    input  logic [1:0] col_a,
    input  logic [1:0] row_a,
    input  logic       closed_a,
    input  logic [1:0] col_b,
    input  logic [1:0] row_b,
    input  logic       closed_b,
    output line_vec_t  keypad_rows
);

    line_vec_t rows_a;
    line_vec_t rows_b;

    // A closed contact only conducts while its column is driven low
    assign rows_a = (closed_a && !keypad_cols[col_a]) ? (line_vec_t'(1) << row_a) : '0;
    assign rows_b = (closed_b && !keypad_cols[col_b]) ? (line_vec_t'(1) << row_b) : '0;

    assign keypad_rows = rows_a | rows_b;   // Rows are active high

endmodule

// File: test/tb_keypad_display.sv
/*
 * Keypad display testbench
 * Presses every key with contact bounce, checks strobes, history and display refresh
 */
`timescale 1ns/100ps

module tb_keypad_display
    import keypad_pkg::*;
();

    localparam int          CLK_PERIOD      = 8;
    localparam int          RESET_CYCLES    = 5;
    localparam logic [31:0] LFSR_SEED       = 32'h8a9029fc;
    localparam logic [31:0] LFSR_TAPS       = 32'h80200003;
    localparam int          BOUNCE_CYCLES   = 5;
    localparam int          NORMAL_HOLD     = 40;
    localparam int          LONG_HOLD       = 200;
    localparam int          GLITCH_CYCLES   = 5;
    localparam int          RELEASE_GAP     = 20;
    localparam int          LATENCY_MAX     = SYNC_STAGES + 4 * SCAN_DWELL + DEBOUNCE_CYCLES + 2;
    localparam int          WATCHDOG_CYCLES =
        16 * (NORMAL_HOLD + RELEASE_GAP + 2 * BOUNCE_CYCLES + LATENCY_MAX) + LONG_HOLD + 800;

    // Reference key map, [column][row]
    localparam key_code_t REF_KEYS [4][4] = '{
        '{4'h1, 4'h4, 4'h7, 4'hA},
        '{4'h2, 4'h5, 4'h8, 4'h0},
        '{4'h3, 4'h6, 4'h9, 4'hB},
        '{4'hC, 4'hD, 4'hE, 4'hF}
    };

    logic        clk = 1'b0;
    logic        rst_n;
    line_vec_t   keypad_rows;
    line_vec_t   keypad_cols;
    seg_t        seg;
    logic [1:0]  digit_en;
    logic        key_valid;
    logic [1:0]  col_a;
    logic [1:0]  row_a;
    logic        closed_a;
    logic [1:0]  col_b;
    logic [1:0]  row_b;
    logic        closed_b;
    logic [31:0] lfsr_state;
    key_code_t   exp_newest;
    key_code_t   exp_previous;
    seg_t        exp_seg;
    logic        valid_allowed;
    logic        count_clear;
    logic        lat_run;
    logic        press_done;
    logic        seg_check_en;
    logic        check_reset_state;
    logic [1:0]  en_prev;
    logic        en_toggled;
    int          pulse_count;
    int          lat_cnt;
    int          en_run;
    int          error_count;
    string       test_name;

    keypad_display_top keypad_display_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .keypad_rows (keypad_rows),
        .keypad_cols (keypad_cols),
        .seg         (seg),
        .digit_en    (digit_en),
        .key_valid   (key_valid)
    );

    keypad_model keypad_model_i (
        .keypad_cols (keypad_cols),
        .col_a       (col_a),
        .row_a       (row_a),
        .closed_a    (closed_a),
        .col_b       (col_b),
        .row_b       (row_b),
        .closed_b    (closed_b),
        .keypad_rows (keypad_rows)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // Glyphs listed as the lit segments of each hex digit
    function automatic seg_t glyph_of(input key_code_t value);
        string      lit;
        seg_t       pattern;
        logic [7:0] idx;
        case (value)
            4'h0: lit = "abcdef";
            4'h1: lit = "bc";
            4'h2: lit = "abdeg";
            4'h3: lit = "abcdg";
            4'h4: lit = "bcfg";
            4'h5: lit = "acdfg";
            4'h6: lit = "acdefg";
            4'h7: lit = "abc";
            4'h8: lit = "abcdefg";
            4'h9: lit = "abcdfg";
            4'hA: lit = "abcefg";
            4'hB: lit = "cdefg";
            4'hC: lit = "adef";
            4'hD: lit = "bcdeg";
            4'hE: lit = "adefg";
            default: lit = "aefg";
        endcase
        pattern = '1;
        for (int i = 0; i < lit.len(); i++) begin
            idx = lit[i] - 8'd97;       // Segment a is bit 0
            pattern[idx[2:0]] = 1'b0;
        end
        return pattern;
    endfunction

    // Low digit_en bit 1 enables the newest digit
    assign exp_seg = glyph_of((digit_en[1] == 1'b0) ? exp_newest : exp_previous);

    always @(posedge clk) begin
        if (count_clear) begin
            pulse_count <= 0;
            lat_cnt     <= 0;
        end else begin
            if (key_valid) begin
                pulse_count <= pulse_count + 1;
            end
            if (lat_run) begin
                lat_cnt <= lat_cnt + 1;     // Cycles since contacts settled
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_prev    <= 2'b01;
            en_run     <= 0;
            en_toggled <= 1'b0;
        end else begin
            en_prev <= digit_en;
            if (digit_en != en_prev) begin
                en_run     <= 1;
                en_toggled <= 1'b1;
            end else begin
                en_run <= en_run + 1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
        check_reset_state |-> (digit_en == 2'b01 && !key_valid && keypad_cols == 4'b1110))
        else begin
            error_count++;
            $write("Mismatch %s: digit_en expected 01 actual %b, ",
                   test_name, $sampled(digit_en));
            $display("key_valid expected 0 actual %b, keypad_cols expected 1110 actual %b",
                     $sampled(key_valid), $sampled(keypad_cols));
        end

    a_valid_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> valid_allowed)
        else begin
            error_count++;
            $display("Mismatch %s: key_valid expected 0 actual 1", test_name);
        end

    a_valid_once: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> (pulse_count == 0))
        else begin
            error_count++;
            $display("Mismatch %s: key_valid pulses expected 1 actual %0d",
                     test_name, $sampled(pulse_count) + 1);
        end

    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> (lat_cnt <= LATENCY_MAX))
        else begin
            error_count++;
            $display("%s: key_valid came %0d cycles after the contacts settled, limit is %0d",
                     test_name, $sampled(lat_cnt), LATENCY_MAX);
        end

    a_pulse_seen: assert property (@(posedge clk) disable iff (!rst_n)
        press_done |-> (pulse_count == 1))
        else begin
            error_count++;
            $display("Mismatch %s: key_valid pulses expected 1 actual %0d",
                     test_name, $sampled(pulse_count));
        end

    a_seg_glyph: assert property (@(posedge clk) disable iff (!rst_n)
        seg_check_en |-> (seg == exp_seg))
        else begin
            error_count++;
            $display("Mismatch %s: seg expected %b actual %b with digit_en %b",
                     test_name, $sampled(exp_seg), $sampled(seg), $sampled(digit_en));
        end

    a_refresh_period: assert property (@(posedge clk) disable iff (!rst_n)
        (en_toggled && digit_en != en_prev) |-> (en_run == REFRESH_CYCLES && digit_en == ~en_prev))
        else begin
            error_count++;
            $display("Mismatch %s: digit_en period expected %0d actual %0d, value %b after %b",
                     test_name, REFRESH_CYCLES, $sampled(en_run), $sampled(digit_en),
                     $sampled(en_prev));
        end

    a_refresh_bound: assert property (@(posedge clk) disable iff (!rst_n)
        en_toggled |-> (en_run <= REFRESH_CYCLES))
        else begin
            error_count++;
            $display("%s: digit_en held its value longer than %0d cycles", test_name, REFRESH_CYCLES);
        end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Contact chatter, one LFSR step per bounce bit
    task automatic bounce_a();
        for (int i = 0; i < BOUNCE_CYCLES; i++) begin
            @(posedge clk);
            lfsr_state = lfsr_step(lfsr_state);
            closed_a <= lfsr_state[0];
        end
    endtask

    task automatic press_key(input logic [1:0] col, input logic [1:0] row, input int hold);
        @(posedge clk);
        col_a         <= col;
        row_a         <= row;
        count_clear   <= 1'b1;
        valid_allowed <= 1'b1;
        seg_check_en  <= 1'b0;      // Display moves during the press
        @(posedge clk);
        count_clear <= 1'b0;
        bounce_a();
        @(posedge clk);
        closed_a <= 1'b1;
        lat_run  <= 1'b1;
        wait_cycles(hold);
        bounce_a();
        @(posedge clk);
        closed_a <= 1'b0;
        lat_run  <= 1'b0;
        wait_cycles(RELEASE_GAP);
        @(posedge clk);
        press_done    <= 1'b1;
        valid_allowed <= 1'b0;
        seg_check_en  <= 1'b1;
        exp_previous  <= exp_newest;
        exp_newest    <= REF_KEYS[col][row];
        @(posedge clk);
        press_done <= 1'b0;
    endtask

    // Presses the scanner must reject, short glitch or two rows at once
    task automatic bad_press(input logic [1:0] ca, input logic [1:0] ra,
                             input logic [1:0] cb, input logic [1:0] rb,
                             input logic both, input int len);
        @(posedge clk);
        col_a    <= ca;
        row_a    <= ra;
        col_b    <= cb;
        row_b    <= rb;
        // Close as the scan drives this column low, so the scanner captures the hit
        while (keypad_cols[ca] !== 1'b0) begin
            @(posedge clk);
        end
        while (keypad_cols[ca] !== 1'b1) begin
            @(posedge clk);
        end
        wait_cycles(3 * SCAN_DWELL - 1);
        closed_a <= 1'b1;
        closed_b <= both;
        wait_cycles(len);
        closed_a <= 1'b0;
        closed_b <= 1'b0;
        wait_cycles(2 * RELEASE_GAP);
    endtask

    initial begin
        rst_n             = 1'b0;
        col_a             = 2'd0;
        row_a             = 2'd0;
        closed_a          = 1'b0;
        col_b             = 2'd0;
        row_b             = 2'd0;
        closed_b          = 1'b0;
        lfsr_state        = LFSR_SEED;
        exp_newest        = 4'h0;
        exp_previous      = 4'h0;
        valid_allowed     = 1'b0;
        count_clear       = 1'b0;
        lat_run           = 1'b0;
        press_done        = 1'b0;
        seg_check_en      = 1'b1;
        check_reset_state = 1'b0;
        error_count       = 0;
        test_name         = "reset_idle";
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n             <= 1'b1;
        check_reset_state <= 1'b1;
        @(posedge clk);
        check_reset_state <= 1'b0;
        wait_cycles(4 * REFRESH_CYCLES);

        test_name = "all_keys";
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                press_key(2'(c), 2'(r), NORMAL_HOLD);
            end
        end

        test_name = "long_hold";
        press_key(2'd3, 2'd2, LONG_HOLD);

        test_name = "glitch";
        bad_press(2'd0, 2'd0, 2'd0, 2'd0, 1'b0, GLITCH_CYCLES);

        test_name = "two_rows";
        bad_press(2'd1, 2'd0, 2'd1, 2'd2, 1'b1, NORMAL_HOLD);

        test_name = "refresh";
        wait_cycles(6 * REFRESH_CYCLES);

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Checks finished with %0d errors", error_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: compile.f
source/keypad_pkg.sv
source/seven_seg_decoder.sv
source/keypad_scanner.sv
source/key_history.sv
source/display_mux.sv
source/keypad_display_top.sv
test/keypad_model.sv
test/tb_keypad_display.sv

// File: Makefile
VERILATOR  := verilator
TOP        := tb_keypad_display
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(BUILD_DIR)
FAIL_MSG   := TESTBENCH FAILED
PASS_MSG   := TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
